// ==== source/l_function_macros.svh ====
// BIKE L-function front end sizes, padding bytes and derived counts
`ifndef L_FUNCTION_MACROS_SVH
`define L_FUNCTION_MACROS_SVH

// Base sizes
`define R_BITS        1400
`define WORD_BITS     32
`define RATE_BITS     832
`define L_BITS        256
`define BLOCK_WORDS   26
`define L_WORDS       8

// Error vector layout, one vector per memory
`define R_BYTES       ((`R_BITS + 7) / 8)
`define DWORDS        ((`R_BYTES + 3) / 4)
// Bytes of e0 that sit in its last word
`define OVER_BYTES    (`R_BYTES % 4)

// Joined message and the blocks it fills, one pad byte at least
`define MSG_BYTES     (2 * `R_BYTES)
`define TOTAL_BLOCKS  ((`MSG_BYTES + 1 + `RATE_BITS / 8 - 1) / (`RATE_BITS / 8))
`define TOTAL_WORDS   (`TOTAL_BLOCKS * `BLOCK_WORDS)

// Index widths
`define ADDR_BITS     ($clog2(`DWORDS))
`define IDX_BITS      ($clog2(`TOTAL_WORDS))

// SHA3 domain and final pad bytes
`define PAD_FIRST     8'h06
`define PAD_LAST      8'h80

`endif

// ==== source/l_function_pkg.sv ====
// Shared word, request, block and L output types of the L-function front end
`include "l_function_macros.svh"

package l_function_pkg;

    // ------------------------------------------------------------------------
    // Plain vectors
    // ------------------------------------------------------------------------
    typedef logic [`WORD_BITS-1:0] word_t;

    // Rate block, word 0 in the lowest bits
    typedef logic [`RATE_BITS-1:0] block_t;

    // First L_BITS of the Keccak state
    typedef logic [`L_BITS-1:0] hash_t;

    // ------------------------------------------------------------------------
    // Structs
    // ------------------------------------------------------------------------
    // One memory read port
    typedef struct packed {
        logic                  rd;
        logic [`ADDR_BITS-1:0] addr;
    } mem_rd_t;

    // Message word request from the sequencer
    typedef struct packed {
        logic                 valid;
        logic [`IDX_BITS-1:0] idx;
    } word_req_t;

    // Message word with its stream index
    typedef struct packed {
        logic                 valid;
        logic [`IDX_BITS-1:0] idx;
        word_t                data;
    } msg_word_t;

    // One L output beat
    typedef struct packed {
        logic       valid;
        logic [2:0] addr;
        word_t      data;
    } l_beat_t;

endpackage

// ==== source/l_control.sv ====
// Sequencer FSM for the L-function, issues word requests, starts Keccak, unloads L
`include "l_function_macros.svh"

module l_control (
    input  logic                      CLK,
    input  logic                      RESETN,
    input  logic                      HASH_EN,
    input  logic                      block_full,
    input  logic                      KECCAK_DONE,
    input  logic                      unload_last,
    output l_function_pkg::word_req_t word_req,
    output logic                      KECCAK_START,
    output logic                      unload_start,
    output logic                      DONE
);

    // ------------------------------------------------------------------------
    // Counter widths and limits
    // ------------------------------------------------------------------------
    localparam int IW = `IDX_BITS;
    localparam int BW = $clog2(`BLOCK_WORDS);
    localparam int BC = $clog2(`TOTAL_BLOCKS + 1);

    localparam logic [BW-1:0] LAST_WORD  = BW'(`BLOCK_WORDS - 1);
    localparam logic [BC-1:0] LAST_BLOCK = BC'(`TOTAL_BLOCKS - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQUEST,
        S_WAIT_BLOCK,
        S_WAIT_KECCAK,
        S_UNLOAD,
        S_DONE
    } state_t;

    state_t          state;
    // Message word index over the whole hash
    logic [IW-1:0]   idx;
    // Request position inside the current block
    logic [BW-1:0]   word_cnt;
    // Blocks already absorbed
    logic [BC-1:0]   block_cnt;

    // ------------------------------------------------------------------------
    // FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            state        <= S_IDLE;
            idx          <= '0;
            word_cnt     <= '0;
            block_cnt    <= '0;
            KECCAK_START <= 1'b0;
            unload_start <= 1'b0;
        end else begin
            // Pulses by default
            KECCAK_START <= 1'b0;
            unload_start <= 1'b0;

            case (state)
                S_IDLE: begin
                    // New hash, index restarts at word 0
                    if (HASH_EN) begin
                        idx       <= '0;
                        word_cnt  <= '0;
                        block_cnt <= '0;
                        state     <= S_REQUEST;
                    end
                end

                S_REQUEST: begin
                    // One request per cycle, 26 in a row
                    idx <= idx + 1'b1;
                    if (word_cnt == LAST_WORD) begin
                        word_cnt <= '0;
                        state    <= S_WAIT_BLOCK;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end

                S_WAIT_BLOCK: begin
                    // Last word has passed read and pad stages
                    if (block_full) begin
                        KECCAK_START <= 1'b1;
                        state        <= S_WAIT_KECCAK;
                    end
                end

                S_WAIT_KECCAK: begin
                    if (KECCAK_DONE) begin
                        if (block_cnt == LAST_BLOCK) begin
                            // Hash is final, HASH_IN now stable
                            unload_start <= 1'b1;
                            state        <= S_UNLOAD;
                        end else begin
                            block_cnt <= block_cnt + 1'b1;
                            state     <= S_REQUEST;
                        end
                    end
                end

                S_UNLOAD: begin
                    if (unload_last) begin
                        state <= S_DONE;
                    end
                end

                S_DONE: begin
                    state <= S_IDLE;
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Outputs decoded from state
    // ------------------------------------------------------------------------
    assign word_req = '{valid: (state == S_REQUEST), idx: idx};

    // Single cycle, right after the last L beat
    assign DONE = (state == S_DONE);

endmodule

// ==== source/error_reorder.sv ====
// Reads e0 and e1 word by word and joins them into one byte-aligned message stream
`include "l_function_macros.svh"

module error_reorder (
    input  logic                      CLK,
    input  logic                      RESETN,
    input  l_function_pkg::word_req_t word_req,
    output l_function_pkg::mem_rd_t   ERROR0_RD,
    output l_function_pkg::mem_rd_t   ERROR1_RD,
    input  l_function_pkg::word_t     ERROR0_DIN,
    input  l_function_pkg::word_t     ERROR1_DIN,
    output l_function_pkg::msg_word_t msg_word
);

    localparam int IW = `IDX_BITS;
    localparam int AW = `ADDR_BITS;
    localparam int WB = `WORD_BITS;
    // Overhang in bytes, a full word when e0 ends on a word boundary
    localparam int OV = (`OVER_BYTES == 0) ? 4 : `OVER_BYTES;

    // Word that holds the e0/e1 seam, and the last e1 read
    localparam logic [IW-1:0] BOUNDARY = IW'(`DWORDS - 1);
    localparam logic [IW-1:0] E1_END   = IW'(2 * `DWORDS - 2);

    logic [IW-1:0]      e1_off;
    logic               valid_d;
    logic [IW-1:0]      idx_d;
    // High bytes of the previous e1 word
    logic [8*OV-1:0]    e1_hi;
    logic [WB+8*OV-1:0] join_e0;
    logic [WB+8*OV-1:0] join_e1;
    l_function_pkg::word_t data;

    // ------------------------------------------------------------------------
    // Read addresses, combinational from the request
    // ------------------------------------------------------------------------
    assign e1_off = word_req.idx - BOUNDARY;

    assign ERROR0_RD = '{rd: word_req.valid && (word_req.idx <= BOUNDARY),
                         addr: word_req.idx[AW-1:0]};

    // e1 runs one word ahead so its low bytes land in the seam word
    assign ERROR1_RD = '{rd: word_req.valid && (word_req.idx >= BOUNDARY)
                             && (word_req.idx <= E1_END),
                         addr: e1_off[AW-1:0]};

    // ------------------------------------------------------------------------
    // Index delay matching the memory latency
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            valid_d <= 1'b0;
        end else begin
            valid_d <= word_req.valid;
        end
    end

    always_ff @(posedge CLK) begin
        idx_d <= word_req.idx;
        // Carried into the next message word
        if (valid_d) begin
            e1_hi <= ERROR1_DIN[WB-1 -: 8*OV];
        end
    end

    // ------------------------------------------------------------------------
    // Word assembly
    // ------------------------------------------------------------------------
    assign join_e0 = {ERROR1_DIN, ERROR0_DIN[8*OV-1:0]};
    assign join_e1 = {ERROR1_DIN, e1_hi};

    always_comb begin
        if (idx_d < BOUNDARY) begin
            data = ERROR0_DIN;
        end else if (idx_d == BOUNDARY) begin
            data = join_e0[WB-1:0];
        end else begin
            data = join_e1[WB-1:0];
        end
        // Nothing past the message
        for (int k = 0; k < 4; k++) begin
            if (int'(idx_d) * 4 + k >= `MSG_BYTES) begin
                data[8*k +: 8] = 8'h00;
            end
        end
    end

    assign msg_word = '{valid: valid_d, idx: idx_d, data: data};

endmodule

// ==== source/msg_pad.sv ====
// SHA3 padding stage, places the domain byte and the final pad bit by byte position
`include "l_function_macros.svh"

module msg_pad (
    input  logic                      CLK,
    input  logic                      RESETN,
    input  l_function_pkg::msg_word_t msg_word,
    output l_function_pkg::msg_word_t pad_word
);

    localparam int IW = `IDX_BITS;
    // Byte 103 of the last block
    localparam int LAST_BYTE = 4 * `TOTAL_WORDS - 1;

    logic                  valid_q;
    logic [IW-1:0]         idx_q;
    l_function_pkg::word_t data_q;
    l_function_pkg::word_t padded;
    // Stream position of byte 0 of this word
    int                    base;

    // ------------------------------------------------------------------------
    // Pad insertion
    // ------------------------------------------------------------------------
    always_comb begin
        base   = int'(msg_word.idx) * 4;
        padded = msg_word.data;
        for (int k = 0; k < 4; k++) begin
            // First byte after the message, zero on input
            if (base + k == `MSG_BYTES) begin
                padded[8*k +: 8] = `PAD_FIRST;
            end
            // May share a byte with PAD_FIRST
            if (base + k == LAST_BYTE) begin
                padded[8*k +: 8] = padded[8*k +: 8] | `PAD_LAST;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= msg_word.valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (msg_word.valid) begin
            idx_q  <= msg_word.idx;
            data_q <= padded;
        end
    end

    assign pad_word = '{valid: valid_q, idx: idx_q, data: data_q};

endmodule

// ==== source/block_buffer.sv ====
// Collects 26 padded words into one 832-bit rate block for the Keccak core
`include "l_function_macros.svh"

module block_buffer (
    input  logic                      CLK,
    input  logic                      RESETN,
    input  l_function_pkg::msg_word_t pad_word,
    output l_function_pkg::block_t    block,
    output logic                      block_full
);

    localparam int SW = $clog2(`BLOCK_WORDS);
    localparam int WB = `WORD_BITS;
    localparam logic [SW-1:0] LAST_SLOT = SW'(`BLOCK_WORDS - 1);

    // Word slots of the current block
    l_function_pkg::word_t slots [`BLOCK_WORDS];
    logic [SW-1:0]         slot;

    // Slot decode from the stream index
    assign slot = SW'(pad_word.idx % `BLOCK_WORDS);

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            for (int i = 0; i < `BLOCK_WORDS; i++) begin
                slots[i] <= '0;
            end
        end else if (pad_word.valid) begin
            slots[slot] <= pad_word.data;
        end
    end

    // Word 0 in the lowest bits
    always_comb begin
        for (int i = 0; i < `BLOCK_WORDS; i++) begin
            block[WB*i +: WB] = slots[i];
        end
    end

    // Block complete once slot 25 lands, stable from the next cycle
    assign block_full = pad_word.valid && (slot == LAST_SLOT);

endmodule

// ==== source/hash_unload.sv ====
// Unloads the 256-bit hash as eight addressed L words, most significant word first
`include "l_function_macros.svh"

module hash_unload (
    input  logic                    CLK,
    input  logic                    RESETN,
    input  logic                    unload_start,
    input  l_function_pkg::hash_t   HASH_IN,
    output l_function_pkg::l_beat_t L,
    output logic                    unload_last
);

    localparam int WB = `WORD_BITS;
    localparam logic [2:0] LAST_BEAT = 3'(`L_WORDS - 1);

    // Unload in progress
    logic                  active;
    // Beat number, also the L address
    logic [2:0]            beat;
    l_function_pkg::word_t slice;

    // ------------------------------------------------------------------------
    // Beat counter
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            active <= 1'b0;
            beat   <= '0;
        end else if (unload_start) begin
            active <= 1'b1;
            beat   <= '0;
        end else if (active) begin
            // Eight beats back to back, then idle
            if (beat == LAST_BEAT) begin
                active <= 1'b0;
            end
            beat <= beat + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Word select
    // ------------------------------------------------------------------------
    // Beat 0 takes the top slice of the hash
    assign slice = HASH_IN[WB * (`L_WORDS - 1 - int'(beat)) +: WB];

    assign L = '{valid: active, addr: beat, data: slice};

    // Tells the sequencer this is the eighth beat
    assign unload_last = active && (beat == LAST_BEAT);

endmodule

// ==== source/l_function_top.sv ====
// BIKE L-function front end, message preparation and L unloading around Keccak
module l_function_top (
    input  logic                      CLK,
    input  logic                      RESETN,
    input  logic                      HASH_EN,
    output logic                      DONE,
    output l_function_pkg::mem_rd_t   ERROR0_RD,
    output l_function_pkg::mem_rd_t   ERROR1_RD,
    input  l_function_pkg::word_t     ERROR0_DIN,
    input  l_function_pkg::word_t     ERROR1_DIN,
    output logic                      KECCAK_START,
    output l_function_pkg::block_t    KECCAK_BLOCK,
    input  logic                      KECCAK_DONE,
    input  l_function_pkg::hash_t     HASH_IN,
    output l_function_pkg::l_beat_t   L
);

    // ------------------------------------------------------------------------
    // Internal links
    // ------------------------------------------------------------------------
    // Sequencer to memory read stage
    l_function_pkg::word_req_t word_req;
    // Joined message word, then padded
    l_function_pkg::msg_word_t msg_word;
    l_function_pkg::msg_word_t pad_word;
    logic                      block_full;
    logic                      unload_start;
    logic                      unload_last;

    // ------------------------------------------------------------------------
    // Sequencer
    // ------------------------------------------------------------------------
    l_control u_control (
        .CLK          (CLK),
        .RESETN       (RESETN),
        .HASH_EN      (HASH_EN),
        .block_full   (block_full),
        .KECCAK_DONE  (KECCAK_DONE),
        .unload_last  (unload_last),
        .word_req     (word_req),
        .KECCAK_START (KECCAK_START),
        .unload_start (unload_start),
        .DONE         (DONE)
    );

    // ------------------------------------------------------------------------
    // Message path, read and join, pad, collect
    // ------------------------------------------------------------------------
    error_reorder u_reorder (
        .CLK        (CLK),
        .RESETN     (RESETN),
        .word_req   (word_req),
        .ERROR0_RD  (ERROR0_RD),
        .ERROR1_RD  (ERROR1_RD),
        .ERROR0_DIN (ERROR0_DIN),
        .ERROR1_DIN (ERROR1_DIN),
        .msg_word   (msg_word)
    );

    msg_pad u_pad (
        .CLK      (CLK),
        .RESETN   (RESETN),
        .msg_word (msg_word),
        .pad_word (pad_word)
    );

    // Block stays put while Keccak absorbs it
    block_buffer u_buffer (
        .CLK        (CLK),
        .RESETN     (RESETN),
        .pad_word   (pad_word),
        .block      (KECCAK_BLOCK),
        .block_full (block_full)
    );

    // ------------------------------------------------------------------------
    // L output
    // ------------------------------------------------------------------------
    hash_unload u_unload (
        .CLK          (CLK),
        .RESETN       (RESETN),
        .unload_start (unload_start),
        .HASH_IN      (HASH_IN),
        .L            (L),
        .unload_last  (unload_last)
    );

endmodule

// ==== tb/error_bram_model.sv ====
// Error-vector memory model, one-cycle synchronous read plus a load port for the testbench
`include "l_function_macros.svh"

module error_bram_model (
    input  logic                    CLK,
    input  l_function_pkg::mem_rd_t rd,
    input  logic                    wr_en,
    input  logic [`ADDR_BITS-1:0]   wr_addr,
    input  l_function_pkg::word_t   wr_data,
    output l_function_pkg::word_t   dout
);

    timeunit 1ns;
    timeprecision 100ps;

    // Full address space, only the first DWORDS entries carry the vector
    localparam int DEPTH = 2 ** `ADDR_BITS;

    l_function_pkg::word_t mem [DEPTH];

    // ------------------------------------------------------------------------
    // Load port, used only while the DUT is idle
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ------------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------------
    // Data one cycle after the strobe, held while no read is issued
    always_ff @(posedge CLK) begin
        if (rd.rd) begin
            dout <= mem[rd.addr];
        end
    end

endmodule

// ==== tb/l_function_tb.sv ====
// Testbench for the L-function front end, random vectors against a byte-stream model
`include "l_function_macros.svh"

module l_function_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // ------------------------------------------------------------------------
    // Sizes worked out from the base constants
    // ------------------------------------------------------------------------
    localparam int R_BITS       = `R_BITS;
    localparam int R_BYTES      = (R_BITS + 7) / 8;
    localparam int DWORDS       = (R_BYTES + 3) / 4;
    localparam int MSG_BYTES    = 2 * R_BYTES;
    localparam int BLOCK_BYTES  = `RATE_BITS / 8;
    localparam int TOTAL_BLOCKS = (MSG_BYTES + BLOCK_BYTES) / BLOCK_BYTES;
    localparam int STREAM_BYTES = TOTAL_BLOCKS * BLOCK_BYTES;
    localparam int L_BITS       = `L_BITS;
    localparam int L_WORDS      = L_BITS / 32;
    localparam int ADDR_W       = `ADDR_BITS;
    localparam int RUNS         = 3;
    localparam int TIMEOUT_CYCLES = RUNS * (TOTAL_BLOCKS * 55 + 40) + 200;

    localparam logic [7:0] DOMAIN_BYTE = 8'h06;
    localparam logic [7:0] FINAL_BIT   = 8'h80;

    // DUT side
    logic                      clk;
    logic                      resetn;
    logic                      hash_en;
    logic                      done;
    l_function_pkg::mem_rd_t   e0_rd;
    l_function_pkg::mem_rd_t   e1_rd;
    l_function_pkg::word_t     e0_din;
    l_function_pkg::word_t     e1_din;
    logic                      keccak_start;
    l_function_pkg::block_t    keccak_block;
    logic                      keccak_done;
    l_function_pkg::hash_t     hash_in;
    l_function_pkg::l_beat_t   l_out;

    // Memory load port
    logic                      mem_wr_en;
    logic [ADDR_W-1:0]         mem_wr_addr;
    l_function_pkg::word_t     e0_wr_data;
    l_function_pkg::word_t     e1_wr_data;

    // Reference data for the current run
    l_function_pkg::word_t     e0_words [DWORDS];
    l_function_pkg::word_t     e1_words [DWORDS];
    logic [7:0]                stream [STREAM_BYTES];
    l_function_pkg::block_t    expected_blocks [TOTAL_BLOCKS];
    l_function_pkg::hash_t     expected_hash;

    // Per-run bookkeeping
    int   cycle_count = 0;
    int   run_idx;
    int   start_count;
    int   beat_count;
    int   done_count;
    int   last_beat_cycle;
    logic keccak_busy;

    l_function_top u_l_function_top (
        .CLK          (clk),
        .RESETN       (resetn),
        .HASH_EN      (hash_en),
        .DONE         (done),
        .ERROR0_RD    (e0_rd),
        .ERROR1_RD    (e1_rd),
        .ERROR0_DIN   (e0_din),
        .ERROR1_DIN   (e1_din),
        .KECCAK_START (keccak_start),
        .KECCAK_BLOCK (keccak_block),
        .KECCAK_DONE  (keccak_done),
        .HASH_IN      (hash_in),
        .L            (l_out)
    );

    error_bram_model u_e0_mem (
        .CLK     (clk),
        .rd      (e0_rd),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (e0_wr_data),
        .dout    (e0_din)
    );

    error_bram_model u_e1_mem (
        .CLK     (clk),
        .rd      (e1_rd),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (e1_wr_data),
        .dout    (e1_din)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Failure reporting and compare tasks
    // ------------------------------------------------------------------------
    task automatic report_failure(input string reason);
        $display("Checks failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_block(input string name, input l_function_pkg::block_t expected,
                               input l_function_pkg::block_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            report_failure("rate block differs from the model");
        end
    endtask

    task automatic check_l_beat(input string name, input l_function_pkg::l_beat_t expected,
                                input l_function_pkg::l_beat_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            report_failure("L beat differs from the hash slice");
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
            report_failure("count differs from the expected value");
        end
    endtask

    // Cycle limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure("timeout, DONE of the last hash never arrived");
        end
    end

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    // Random vectors, bits from R_BITS upward forced to zero
    task automatic randomize_vectors();
        for (int w = 0; w < DWORDS; w++) begin
            e0_words[w] = $urandom();
            e1_words[w] = $urandom();
            for (int i = 0; i < 32; i++) begin
                if (32 * w + i >= R_BITS) begin
                    e0_words[w][i] = 1'b0;
                    e1_words[w][i] = 1'b0;
                end
            end
        end
    endtask

    // e0 bytes, e1 bytes right behind, then domain byte, zero fill and final bit
    task automatic build_model();
        logic [7:0] v;
        for (int b = 0; b < STREAM_BYTES; b++) begin
            if (b < R_BYTES) begin
                v = e0_words[b / 4][8 * (b % 4) +: 8];
            end else if (b < MSG_BYTES) begin
                v = e1_words[(b - R_BYTES) / 4][8 * ((b - R_BYTES) % 4) +: 8];
            end else begin
                v = 8'h00;
            end
            if (b == MSG_BYTES) begin
                v = DOMAIN_BYTE;
            end
            if (b == STREAM_BYTES - 1) begin
                v = v | FINAL_BIT;
            end
            stream[b] = v;
        end
        // Byte 0 of each block in the lowest bits
        for (int k = 0; k < TOTAL_BLOCKS; k++) begin
            for (int j = 0; j < BLOCK_BYTES; j++) begin
                expected_blocks[k][8 * j +: 8] = stream[BLOCK_BYTES * k + j];
            end
        end
    endtask

    // Word i of L is the i-th 32-bit slice from the top of the hash
    function automatic l_function_pkg::l_beat_t expected_l_beat(input int i);
        l_function_pkg::l_beat_t beat;
        beat.valid = 1'b1;
        beat.addr  = 3'(i);
        beat.data  = expected_hash[L_BITS - 1 - 32 * i -: 32];
        return beat;
    endfunction

    task automatic load_memories();
        for (int w = 0; w < DWORDS; w++) begin
            @(posedge clk);
            mem_wr_en   <= 1'b1;
            mem_wr_addr <= ADDR_W'(w);
            e0_wr_data  <= e0_words[w];
            e1_wr_data  <= e1_words[w];
        end
        @(posedge clk);
        mem_wr_en <= 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Keccak responder, random latency, new hash before the last done
    // ------------------------------------------------------------------------
    initial begin : keccak_responder
        int                    delay;
        int                    served;
        l_function_pkg::hash_t h;
        served = 0;
        forever begin
            @(negedge clk);
            if (keccak_start === 1'b1) begin
                served = served + 1;
                delay  = 1 + int'($urandom % 20);
                repeat (delay) @(posedge clk);
                if (served % TOTAL_BLOCKS == 0) begin
                    for (int i = 0; i < L_WORDS; i++) begin
                        h[32 * i +: 32] = $urandom();
                    end
                    expected_hash = h;
                    hash_in       <= h;
                end
                keccak_done <= 1'b1;
                @(posedge clk);
                keccak_done <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Output monitor, sampled at the falling edge
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (keccak_start === 1'b1) begin
            if (keccak_busy) begin
                report_failure("KECCAK_START came again before KECCAK_DONE");
            end
            if (start_count >= TOTAL_BLOCKS) begin
                report_failure("more KECCAK_START pulses than blocks in one hash");
            end
            check_block($sformatf("run %0d block %0d", run_idx, start_count),
                        expected_blocks[start_count], keccak_block);
            start_count = start_count + 1;
            keccak_busy = 1'b1;
        end
        if (keccak_done === 1'b1) begin
            keccak_busy = 1'b0;
        end
        if (l_out.valid === 1'b1) begin
            if (start_count != TOTAL_BLOCKS || keccak_busy) begin
                report_failure("L beat before the final KECCAK_DONE");
            end
            if (beat_count >= L_WORDS) begin
                report_failure("more than eight L beats in one hash");
            end
            if (beat_count > 0) begin
                check_count("L beat cycle", last_beat_cycle + 1, cycle_count);
            end
            check_l_beat($sformatf("run %0d L beat %0d", run_idx, beat_count),
                         expected_l_beat(beat_count), l_out);
            beat_count      = beat_count + 1;
            last_beat_cycle = cycle_count;
        end
        if (done === 1'b1) begin
            check_count("L beats before DONE", L_WORDS, beat_count);
            check_count("DONE cycle", last_beat_cycle + 1, cycle_count);
            done_count = done_count + 1;
        end
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin : main_sequence
        int gap;
        void'($urandom(32'h49a7));
        resetn      <= 1'b0;
        hash_en     <= 1'b0;
        keccak_done <= 1'b0;
        hash_in     <= '0;
        mem_wr_en   <= 1'b0;
        mem_wr_addr <= '0;
        e0_wr_data  <= '0;
        e1_wr_data  <= '0;
        keccak_busy  = 1'b0;
        start_count  = 0;
        beat_count   = 0;
        done_count   = 0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;

        // Quiet outputs until the first HASH_EN
        repeat (6) begin
            @(negedge clk);
            if (done !== 1'b0 || keccak_start !== 1'b0 || l_out.valid !== 1'b0
                || e0_rd.rd !== 1'b0 || e1_rd.rd !== 1'b0) begin
                report_failure("an output was not low after reset");
            end
        end

        for (int run = 0; run < RUNS; run++) begin
            run_idx = run;
            randomize_vectors();
            load_memories();
            build_model();
            start_count = 0;
            beat_count  = 0;
            done_count  = 0;
            keccak_busy = 1'b0;
            @(posedge clk);
            hash_en <= 1'b1;
            @(posedge clk);
            hash_en <= 1'b0;
            // Stray HASH_EN while busy, must leave the counts alone
            if (run > 0) begin
                gap = 10 + int'($urandom % 50);
                repeat (gap) @(posedge clk);
                hash_en <= 1'b1;
                @(posedge clk);
                hash_en <= 0;
            end
            while (done_count == 0) begin
                @(negedge clk);
            end
            repeat (5) @(negedge clk);
            check_count("KECCAK_START pulses", TOTAL_BLOCKS, start_count);
            check_count("L beats", L_WORDS, beat_count);
            check_count("DONE pulses", 1, done_count);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+source
source/l_function_pkg.sv
source/l_control.sv
source/error_reorder.sv
source/msg_pad.sv
source/block_buffer.sv
source/hash_unload.sv
source/l_function_top.sv
tb/error_bram_model.sv
tb/l_function_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := l_function_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
FLAGS     := --binary --timing --timescale 1ns/100ps -j 0 --top-module $(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
